//--- common/stream_pkg.sv
package stream_pkg;

   // data word width
   localparam int DATA_W = 32;

   // delay amount width, fifo depth is 2**DELAY_W
   localparam int DELAY_W = 7;

   // tag carried next to each sample on channel b
   localparam int TAG_W = 4;

   // channel a payload
   typedef logic [DATA_W-1:0] word_t;

   // channel b payload, tag and data move as one entry
   typedef struct packed {
      logic [TAG_W-1:0] tag;
      word_t            data;
   } tagged_t;

endpackage

//--- common/cfg_pkg.sv
package cfg_pkg;

   // config port widths
   localparam int CFG_ADDR_W = 2;
   localparam int CFG_DATA_W = 32;

   // register map
   localparam logic [CFG_ADDR_W-1:0] ADDR_AMOUNT_A = 2'd0;
   localparam logic [CFG_ADDR_W-1:0] ADDR_AMOUNT_B = 2'd1;
   localparam logic [CFG_ADDR_W-1:0] ADDR_RUN      = 2'd2;

   // run level sits in this bit of the run register
   localparam int RUN_BIT = 0;

endpackage

//--- common/mem_2p_if.sv
interface mem_2p_if #(
   parameter int  DELAY_W   = 7,
   parameter type payload_t = logic [31:0]
);

   // write port
   logic               w_en;
   logic [DELAY_W-1:0] w_addr;
   payload_t           w_data;

   // read port, data follows one cycle after r_en
   logic               r_en;
   logic [DELAY_W-1:0] r_addr;
   payload_t           r_data;

   // fifo side
   modport ctrl (
      output w_en,
      output w_addr,
      output w_data,
      output r_en,
      output r_addr,
      input  r_data
   );

   // storage side
   modport mem (
      input  w_en,
      input  w_addr,
      input  w_data,
      input  r_en,
      input  r_addr,
      output r_data
   );

endinterface

//--- hdl/ram_2p.sv
module ram_2p #(
   parameter int  DELAY_W   = 7,
   parameter type payload_t = logic [31:0]
) (
   input logic clk,

   mem_2p_if.mem mem
);

   localparam int DEPTH = 2 ** DELAY_W;

   payload_t ram_q [DEPTH];

   // write port
   always_ff @(posedge clk) begin
      if (mem.w_en) begin
         ram_q[mem.w_addr] <= mem.w_data;
      end
   end

   // registered read, r_data holds when r_en is low
   always_ff @(posedge clk) begin
      if (mem.r_en) begin
         mem.r_data <= ram_q[mem.r_addr];
      end
   end

endmodule

//--- delay_buffer/sync_fifo.sv
module sync_fifo #(
   parameter int  DELAY_W   = 7,
   parameter type payload_t = logic [31:0]
) (
   input  logic             clk,
   input  logic             rst,

   // write side
   input  logic             w_en_i,
   input  payload_t         w_data_i,

   // read side
   input  logic             r_en_i,
   output payload_t         r_data_o,

   output logic [DELAY_W:0] level_o,

   // external storage
   mem_2p_if.ctrl           mem
);

   logic [DELAY_W-1:0] w_ptr;
   logic [DELAY_W-1:0] r_ptr;
   logic [DELAY_W:0]   level;

   // pointers wrap at the ram depth
   always_ff @(posedge clk) begin
      if (rst) begin
         w_ptr <= '0;
         r_ptr <= '0;
      end else begin
         if (w_en_i) begin
            w_ptr <= w_ptr + 1'b1;
         end
         if (r_en_i) begin
            r_ptr <= r_ptr + 1'b1;
         end
      end
   end

   // occupancy, unchanged on simultaneous read and write
   always_ff @(posedge clk) begin
      if (rst) begin
         level <= '0;
      end else begin
         case ({w_en_i, r_en_i})
            2'b10:   level <= level + 1'b1;
            2'b01:   level <= level - 1'b1;
            default: level <= level;
         endcase
      end
   end

   assign level_o = level;

   // requests go straight to the ram ports
   assign mem.w_en   = w_en_i;
   assign mem.w_addr = w_ptr;
   assign mem.w_data = w_data_i;

   assign mem.r_en   = r_en_i;
   assign mem.r_addr = r_ptr;

   // ram read register provides the one cycle read latency
   assign r_data_o = mem.r_data;

endmodule

//--- delay_buffer/delay_buffer.sv
module delay_buffer #(
   parameter int  DELAY_W   = 7,
   parameter type payload_t = logic [31:0]
) (
   input  logic               clk,
   input  logic               rst,

   input  logic               running_i,
   input  logic [DELAY_W-1:0] amount_i,

   input  payload_t           in_i,
   output payload_t           out_o,

   // fifo storage
   mem_2p_if.ctrl             mem
);

   logic [DELAY_W:0] level;
   logic [DELAY_W:0] amount_ext;
   logic             rd_en;
   logic             wr_en;
   payload_t         fifo_data;
   payload_t         in_q;

   assign amount_ext = {1'b0, amount_i};

   // fill up to amount, then read and write every cycle
   assign wr_en = running_i && (level <= amount_ext);
   assign rd_en = running_i && (level >= amount_ext);

   sync_fifo #(
      .DELAY_W  (DELAY_W),
      .payload_t(payload_t)
   ) u_fifo (
      .clk     (clk),
      .rst     (rst),
      .w_en_i  (wr_en),
      .w_data_i(in_i),
      .r_en_i  (rd_en),
      .r_data_o(fifo_data),
      .level_o (level),
      .mem     (mem)
   );

   // one cycle path used when amount is zero
   always_ff @(posedge clk) begin
      if (rst) begin
         in_q <= '0;
      end else if (running_i) begin
         in_q <= in_i;
      end
   end

   // the fifo path adds the ram read cycle on top of amount
   always_comb begin
      if (amount_i == '0) begin
         out_o = in_q;
      end else begin
         out_o = fifo_data;
      end
   end

endmodule

//--- hdl/cfg_regs.sv
module cfg_regs #(
   parameter int DELAY_W = stream_pkg::DELAY_W
) (
   input  logic                          clk,
   input  logic                          rst,

   // write strobe port
   input  logic                          cfg_we_i,
   input  logic [cfg_pkg::CFG_ADDR_W-1:0] cfg_addr_i,
   input  logic [cfg_pkg::CFG_DATA_W-1:0] cfg_data_i,

   output logic                          running_o,
   output logic [DELAY_W-1:0]            amount_a_o,
   output logic [DELAY_W-1:0]            amount_b_o
);

   logic               running_q;
   logic [DELAY_W-1:0] amount_a_q;
   logic [DELAY_W-1:0] amount_b_q;

   // unmapped addresses fall through the case untouched
   always_ff @(posedge clk) begin
      if (rst) begin
         running_q  <= 1'b0;
         amount_a_q <= '0;
         amount_b_q <= '0;
      end else if (cfg_we_i) begin
         case (cfg_addr_i)
            cfg_pkg::ADDR_AMOUNT_A: begin
               amount_a_q <= cfg_data_i[DELAY_W-1:0];
            end
            cfg_pkg::ADDR_AMOUNT_B: begin
               amount_b_q <= cfg_data_i[DELAY_W-1:0];
            end
            cfg_pkg::ADDR_RUN: begin
               running_q <= cfg_data_i[cfg_pkg::RUN_BIT];
            end
            default: begin
               running_q <= running_q;
            end
         endcase
      end
   end

   assign running_o  = running_q;
   assign amount_a_o = amount_a_q;
   assign amount_b_o = amount_b_q;

endmodule

//--- hdl/delay_accel_top.sv
module delay_accel_top #(
   parameter int DELAY_W = stream_pkg::DELAY_W
) (
   input  logic                           clk,
   input  logic                           rst,

   // configuration
   input  logic                           cfg_we_i,
   input  logic [cfg_pkg::CFG_ADDR_W-1:0] cfg_addr_i,
   input  logic [cfg_pkg::CFG_DATA_W-1:0] cfg_data_i,

   // channel a, plain words
   input  logic [stream_pkg::DATA_W-1:0]  a_data_i,
   output logic [stream_pkg::DATA_W-1:0]  a_data_o,

   // channel b, tagged samples
   input  logic [stream_pkg::DATA_W-1:0]  b_data_i,
   input  logic [stream_pkg::TAG_W-1:0]   b_tag_i,
   output logic [stream_pkg::DATA_W-1:0]  b_data_o,
   output logic [stream_pkg::TAG_W-1:0]   b_tag_o
);

   logic               running;
   logic [DELAY_W-1:0] amount_a;
   logic [DELAY_W-1:0] amount_b;

   stream_pkg::word_t   a_in;
   stream_pkg::word_t   a_out;
   stream_pkg::tagged_t b_in;
   stream_pkg::tagged_t b_out;

   cfg_regs #(
      .DELAY_W(DELAY_W)
   ) u_cfg (
      .clk       (clk),
      .rst       (rst),
      .cfg_we_i  (cfg_we_i),
      .cfg_addr_i(cfg_addr_i),
      .cfg_data_i(cfg_data_i),
      .running_o (running),
      .amount_a_o(amount_a),
      .amount_b_o(amount_b)
   );

   // pack ports into payloads
   assign a_in        = a_data_i;
   assign b_in.data   = b_data_i;
   assign b_in.tag    = b_tag_i;

   mem_2p_if #(.DELAY_W(DELAY_W), .payload_t(stream_pkg::word_t))   mem_a ();
   mem_2p_if #(.DELAY_W(DELAY_W), .payload_t(stream_pkg::tagged_t)) mem_b ();

   delay_buffer #(
      .DELAY_W  (DELAY_W),
      .payload_t(stream_pkg::word_t)
   ) u_buf_a (
      .clk      (clk),
      .rst      (rst),
      .running_i(running),
      .amount_i (amount_a),
      .in_i     (a_in),
      .out_o    (a_out),
      .mem      (mem_a)
   );

   ram_2p #(.DELAY_W(DELAY_W), .payload_t(stream_pkg::word_t)) u_ram_a (
      .clk(clk),
      .mem(mem_a)
   );

   delay_buffer #(
      .DELAY_W  (DELAY_W),
      .payload_t(stream_pkg::tagged_t)
   ) u_buf_b (
      .clk      (clk),
      .rst      (rst),
      .running_i(running),
      .amount_i (amount_b),
      .in_i     (b_in),
      .out_o    (b_out),
      .mem      (mem_b)
   );

   ram_2p #(.DELAY_W(DELAY_W), .payload_t(stream_pkg::tagged_t)) u_ram_b (
      .clk(clk),
      .mem(mem_b)
   );

   // unpack payloads back onto the ports
   assign a_data_o = a_out;
   assign b_data_o = b_out.data;
   assign b_tag_o  = b_out.tag;

endmodule

//--- verif/tb_clkgen.sv
module tb_clkgen #(
   parameter int PERIOD_NS  = 8,
   parameter int RST_CYCLES = 2
) (
   output logic clk_o,
   output logic rst_o
);
   timeunit 1ns;
   timeprecision 1ps;

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
   end

   // reset released on a falling edge, clear of the sampling edge
   initial begin
      rst_o = 1'b1;
      repeat (RST_CYCLES) @(posedge clk_o);
      @(negedge clk_o);
      rst_o = 1'b0;
   end

endmodule

//--- verif/delay_accel_props.sv
module delay_accel_props #(
   parameter int DELAY_W = 7
) (
   input logic             clk,
   input logic             rst,
   input logic             running_i,
   input logic [DELAY_W:0] amount_ext_i,
   input logic [DELAY_W:0] level_i
);
   timeunit 1ns;
   timeprecision 1ps;

   int unsigned assert_errs = 0;

   // while filling, every cycle adds one entry to the fifo
   fill_moves: assert property (@(posedge clk) disable iff (rst)
      (running_i && (level_i < amount_ext_i)) |=> (level_i == $past(level_i) + 1'b1))
   else begin
      $error("delay buffer idle while below its amount");
      assert_errs++;
   end

   // occupancy is bounded by the programmed amount
   level_bound: assert property (@(posedge clk) disable iff (rst)
      level_i <= amount_ext_i)
   else begin
      $error("fifo level above programmed amount");
      assert_errs++;
   end

   // stopped buffer keeps its fifo level
   idle_quiet: assert property (@(posedge clk) disable iff (rst)
      !running_i |=> (level_i == $past(level_i)))
   else begin
      $error("fifo level moved while running is low");
      assert_errs++;
   end

endmodule

bind delay_buffer delay_accel_props #(.DELAY_W(DELAY_W)) u_props (
   .clk         (clk),
   .rst         (rst),
   .running_i   (running_i),
   .amount_ext_i(amount_ext),
   .level_i     (level)
);

//--- verif/delay_accel_tb.sv
module delay_accel_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int DATA_W    = stream_pkg::DATA_W;
   localparam int TAG_W     = stream_pkg::TAG_W;
   localparam int DELAY_W   = stream_pkg::DELAY_W;
   localparam int PERIOD_NS = 8;
   localparam int MEM_WORDS = 256;

   logic                           clk;
   logic                           rst;
   logic                           rst_init;
   logic                           rst_req;
   logic                           cfg_we;
   logic [cfg_pkg::CFG_ADDR_W-1:0] cfg_addr;
   logic [cfg_pkg::CFG_DATA_W-1:0] cfg_data;
   logic [DATA_W-1:0]              a_data_in;
   logic [DATA_W-1:0]              a_data_out;
   logic [DATA_W-1:0]              b_data_in;
   logic [DATA_W-1:0]              b_data_out;
   logic [TAG_W-1:0]               b_tag_in;
   logic [TAG_W-1:0]               b_tag_out;

   logic [31:0]              pat_mem [MEM_WORDS];
   int unsigned              pat_ptr;
   int unsigned              file_left;
   logic [16:0]              lfsr_state;
   int unsigned              err_cnt;
   int unsigned              check_cnt;
   int unsigned              limit_ns = 0;
   logic [DATA_W-1:0]        q_a [$];
   logic [TAG_W+DATA_W-1:0]  q_b [$];

   tb_clkgen #(.PERIOD_NS(PERIOD_NS), .RST_CYCLES(2)) u_clkgen (
      .clk_o(clk),
      .rst_o(rst_init)
   );

   // extra reset pulses between tests
   assign rst = rst_init || rst_req;

   delay_accel_top #(.DELAY_W(DELAY_W)) dut (
      .clk       (clk),
      .rst       (rst),
      .cfg_we_i  (cfg_we),
      .cfg_addr_i(cfg_addr),
      .cfg_data_i(cfg_data),
      .a_data_i  (a_data_in),
      .a_data_o  (a_data_out),
      .b_data_i  (b_data_in),
      .b_tag_i   (b_tag_in),
      .b_data_o  (b_data_out),
      .b_tag_o   (b_tag_out)
   );

   // taps 17 and 14
   function automatic logic [16:0] lfsr_next(input logic [16:0] s);
      return {s[15:0], s[16] ^ s[13]};
   endfunction

   task automatic rand_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
   endtask

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      check_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("ERR %s got %0h expected %0h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic check_idle();
      check_value("a_data_o", a_data_out, '0);
      check_value("b_data_o", b_data_out, '0);
      check_value("b_tag_o", b_tag_out, '0);
   endtask

   // file rows first, then generated samples
   task automatic next_sample(output logic [31:0] a, output logic [31:0] b,
                              output logic [TAG_W-1:0] tag);
      logic [31:0] t;
      if (file_left > 0) begin
         a = pat_mem[pat_ptr];
         b = pat_mem[pat_ptr+1];
         tag = pat_mem[pat_ptr+2][TAG_W-1:0];
         pat_ptr += 3;
         file_left--;
      end else begin
         rand_bits(32, a);
         rand_bits(32, b);
         rand_bits(TAG_W, t);
         tag = t[TAG_W-1:0];
      end
   endtask

   // entered and left on a falling edge
   task automatic cfg_write(input logic [cfg_pkg::CFG_ADDR_W-1:0] addr,
                            input logic [31:0] data);
      cfg_we = 1'b1;
      cfg_addr = addr;
      cfg_data = data;
      @(negedge clk);
      cfg_we = 1'b0;
   endtask

   task automatic apply_reset();
      logic [31:0] v;
      rst_req = 1'b1;
      repeat (2) @(negedge clk);
      rst_req = 1'b0;
      check_idle();
      // inputs must not reach the outputs while stopped
      rand_bits(32, v);
      a_data_in = v;
      rand_bits(32, v);
      b_data_in = v;
      b_tag_in = v[TAG_W-1:0];
      repeat (2) @(negedge clk);
      check_idle();
   endtask

   task automatic run_test(input int amt_a, input int amt_b, input int n_total);
      logic [31:0]             a;
      logic [31:0]             b;
      logic [TAG_W-1:0]        tag;
      logic [DATA_W-1:0]       exp_a;
      logic [TAG_W+DATA_W-1:0] exp_b;
      q_a.delete();
      q_b.delete();
      for (int j = 0; j <= n_total; j++) begin
         // output now is the sample from amount + 1 cycles back
         if (q_a.size() == amt_a + 1) begin
            exp_a = q_a.pop_front();
            check_value("a_data_o", a_data_out, exp_a);
         end
         if (q_b.size() == amt_b + 1) begin
            exp_b = q_b.pop_front();
            check_value("b_data_o", b_data_out, exp_b[DATA_W-1:0]);
            check_value("b_tag_o", b_tag_out, exp_b[TAG_W+DATA_W-1:DATA_W]);
         end
         if (j < n_total) begin
            next_sample(a, b, tag);
            a_data_in = a;
            b_data_in = b;
            b_tag_in = tag;
            q_a.push_back(a);
            q_b.push_back({tag, b});
            @(negedge clk);
         end
      end
   endtask

   initial begin
      int n_tests;
      int p;
      int cycles;
      int amt_a;
      int amt_b;
      int n_rand;
      int unsigned assert_cnt;
      cfg_we = 1'b0;
      cfg_addr = '0;
      cfg_data = '0;
      a_data_in = '0;
      b_data_in = '0;
      b_tag_in = '0;
      rst_req = 1'b0;
      err_cnt = 0;
      check_cnt = 0;
      lfsr_state = 17'd93426;
      $readmemh("verif/delay_patterns.txt", pat_mem);
      n_tests = pat_mem[0];
      // run time budget from the test lengths
      p = 1;
      cycles = 0;
      for (int t = 0; t < n_tests; t++) begin
         cycles += pat_mem[p] + pat_mem[p+1] + pat_mem[p+2] + pat_mem[p+3] + 16;
         p += 4 + 3 * pat_mem[p+2];
      end
      limit_ns = cycles * PERIOD_NS + 1000;
      wait (rst_init === 1'b0);
      @(negedge clk);
      pat_ptr = 1;
      for (int t = 0; t < n_tests; t++) begin
         amt_a = pat_mem[pat_ptr];
         amt_b = pat_mem[pat_ptr+1];
         file_left = pat_mem[pat_ptr+2];
         n_rand = pat_mem[pat_ptr+3];
         pat_ptr += 4;
         apply_reset();
         cfg_write(cfg_pkg::ADDR_AMOUNT_A, amt_a);
         cfg_write(cfg_pkg::ADDR_AMOUNT_B, amt_b);
         // unmapped address, must leave run and amounts alone
         cfg_write(2'd3, 32'hffff_ffff);
         cfg_write(cfg_pkg::ADDR_RUN, 32'd1);
         run_test(amt_a, amt_b, file_left + n_rand);
         cfg_write(cfg_pkg::ADDR_RUN, 32'd0);
      end
      apply_reset();
      assert_cnt = dut.u_buf_a.u_props.assert_errs + dut.u_buf_b.u_props.assert_errs;
      $display("checks %0d, errors %0d, assertion failures %0d",
               check_cnt, err_cnt, assert_cnt);
      if (err_cnt == 0 && assert_cnt == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

   initial begin
      wait (limit_ns != 0);
      #(limit_ns);
      $display("timeout, tests did not finish within %0d ns", limit_ns);
      $display("Something failed");
      $finish;
   end

endmodule

//--- verif/delay_patterns.txt
// first value is the test count; per test a header: amount_a amount_b n_file n_rand
// then n_file rows of a_data b_data b_tag, all hex; n_rand samples follow from the lfsr
4
0 0 5 a // both channels at amount zero
00000001 10000001 1
00000002 20000002 2
deadbeef cafef00d f
00000000 ffffffff 0
a5a5a5a5 5a5a5a5a 5
3 11 6 28 // different amounts, 3 and 17
11111111 88888888 8
22222222 77777777 7
33333333 66666666 6
44444444 55555555 5
12345678 9abcdef0 c
0f0f0f0f f0f0f0f0 3
7f 7f 4 96 // maximum amount on both channels
01234567 76543210 9
89abcdef fedcba98 a
13579bdf 02468ace b
fdb97531 eca86420 d
5 2 6 a // tag integrity, tags change every sample
aaaa0000 0000aaaa 1
bbbb1111 1111bbbb 2
cccc2222 2222cccc 4
dddd3333 3333dddd 8
eeee4444 4444eeee e
ffff5555 5555ffff 7

//--- delay_accel.f
common/stream_pkg.sv
common/cfg_pkg.sv
common/mem_2p_if.sv
hdl/ram_2p.sv
delay_buffer/sync_fifo.sv
delay_buffer/delay_buffer.sv
hdl/cfg_regs.sv
hdl/delay_accel_top.sv
verif/tb_clkgen.sv
verif/delay_accel_props.sv
verif/delay_accel_tb.sv

//--- Bender.yml
package:
  name: delay_accel

sources:
  - common/stream_pkg.sv
  - common/cfg_pkg.sv
  - common/mem_2p_if.sv
  - hdl/ram_2p.sv
  - delay_buffer/sync_fifo.sv
  - delay_buffer/delay_buffer.sv
  - hdl/cfg_regs.sv
  - hdl/delay_accel_top.sv
  - target: test
    files:
      - verif/tb_clkgen.sv
      - verif/delay_accel_props.sv
      - verif/delay_accel_tb.sv
